//--- bnn_settings.svh
`ifndef BNN_SETTINGS_SVH
`define BNN_SETTINGS_SVH

// ==================================================
// network dimensions
// ==================================================

`define BNN_FEAT_CNT    11 // input features.
`define BNN_FEAT_BITS   4  // unsigned width of one feature.
`define BNN_HIDDEN_CNT  40 // binary hidden neurons.
`define BNN_CLASS_CNT   6  // output classes.

// ==================================================
// derived widths
// ==================================================

`define BNN_SCORE_BITS  6  // holds 0 to 40 agreeing bits.
`define BNN_CLASS_BITS  3  // index of classes 0 to 5.
`define BNN_SUM_BITS    9  // signed neuron sum, -165 to +165.

`endif

//--- bnn_weights.svh
`ifndef BNN_WEIGHTS_SVH
`define BNN_WEIGHTS_SVH

// ==================================================
// hidden layer sign weights
// ==================================================
// neuron n sits in bits [11*n +: 11], feature f at bit f of that group.
// a 1 adds the feature, a 0 subtracts it.
// rows are written from neuron 39 down to neuron 0.

`define BNN_HIDDEN_WEIGHTS { \
    11'b11101100111, \
    11'b11110010010, \
    11'b11001100100, \
    11'b11011110110, \
    11'b11111110110, \
    11'b10110110001, \
    11'b01100010011, \
    11'b00001110001, \
    11'b01001010100, \
    11'b10000111110, \
    11'b00111010011, \
    11'b00110101000, \
    11'b11010100001, \
    11'b10111001100, \
    11'b00000111100, \
    11'b01100111000, \
    11'b11100000001, \
    11'b01101011101, \
    11'b11101111111, \
    11'b00010111011, \
    11'b00010101100, \
    11'b11111100000, \
    11'b10101001110, \
    11'b01010011110, \
    11'b11101110111, \
    11'b00101010011, \
    11'b01110001101, \
    11'b11111000101, \
    11'b11011110000, \
    11'b10000000110, \
    11'b11111010111, \
    11'b00110110000, \
    11'b10100101110, \
    11'b11100011001, \
    11'b10101011011, \
    11'b00100000111, \
    11'b10100000101, \
    11'b00011001000, \
    11'b00111000000, \
    11'b00110011000  \
}

// ==================================================
// output layer sign weights
// ==================================================
// class c sits in bits [40*c +: 40], hidden bit h at bit h of that group.
// a 1 counts the hidden bit when set, a 0 counts it when clear.
// rows are written from class 5 down to class 0.

`define BNN_OUTPUT_WEIGHTS { \
    40'b1010111101_0101011110_1111010101_0001011110, \
    40'b0110111011_0011111110_0100111101_0010001110, \
    40'b1000101011_1111011110_0101010100_1011000101, \
    40'b1010111000_1101100010_0010000100_1000000011, \
    40'b1100011010_0000011011_1000000111_0100111101, \
    40'b0010001011_1100000011_0111000001_0000111001  \
}

`endif

//--- bnn_pkg.sv
`include "bnn_settings.svh"

package bnn_pkg;

    // ==================================================
    // input side
    // ==================================================

    typedef logic [`BNN_FEAT_BITS-1:0] feature_t;

    // feature 0 in the low bits.
    typedef feature_t [`BNN_FEAT_CNT-1:0] feature_vec_t;

    // ==================================================
    // hidden and output side
    // ==================================================

    typedef logic signed [`BNN_SUM_BITS-1:0] neuron_sum_t;

    typedef logic [`BNN_HIDDEN_CNT-1:0] hidden_t;

    typedef logic [`BNN_SCORE_BITS-1:0] score_t;

    typedef score_t [`BNN_CLASS_CNT-1:0] score_vec_t;

    typedef logic [`BNN_CLASS_BITS-1:0] class_t;

endpackage

//--- bnn_hidden_layer.sv
`timescale 1ns/1ps

`include "bnn_settings.svh"
`include "bnn_weights.svh"

module bnn_hidden_layer
    import bnn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  feature_vec_t features,
    output logic         hidden_valid,
    output hidden_t      hidden
);

    localparam logic [`BNN_HIDDEN_CNT*`BNN_FEAT_CNT-1:0] hidden_weights = `BNN_HIDDEN_WEIGHTS;

    hidden_t hidden_next;

    // ==================================================
    // threshold neurons
    // ==================================================

    genvar n;
    generate
        for (n = 0; n < `BNN_HIDDEN_CNT; n++) begin : g_neuron
            neuron_sum_t sum;

            always_comb begin
                sum = '0;
                for (int f = 0; f < `BNN_FEAT_CNT; f++) begin
                    if (hidden_weights[n*`BNN_FEAT_CNT + f]) begin
                        sum = sum + neuron_sum_t'({1'b0, features[f]}); // plus weight.
                    end else begin
                        sum = sum - neuron_sum_t'({1'b0, features[f]}); // minus weight.
                    end
                end
            end

            assign hidden_next[n] = (sum > 0); // zero sum gives 0.
        end
    endgenerate

    // ==================================================
    // stage 1 register
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            hidden_valid <= 1'b0;
        end else begin
            hidden_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            hidden <= hidden_next;
        end
    end

    // strobe must settle once reset has been applied.
    a_hidden_valid_known : assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(hidden_valid)
    );

endmodule

//--- bnn_output_layer.sv
`timescale 1ns/1ps

`include "bnn_settings.svh"
`include "bnn_weights.svh"

module bnn_output_layer
    import bnn_pkg::*;
(
    input  hidden_t    hidden,
    output score_vec_t scores
);

    localparam logic [`BNN_CLASS_CNT*`BNN_HIDDEN_CNT-1:0] output_weights = `BNN_OUTPUT_WEIGHTS;

    // ==================================================
    // agreement counts
    // ==================================================

    genvar c;
    generate
        for (c = 0; c < `BNN_CLASS_CNT; c++) begin : g_class
            hidden_t agree;
            score_t  count;

            // xnor marks hidden bits that match the class sign.
            assign agree = ~(hidden ^ output_weights[c*`BNN_HIDDEN_CNT +: `BNN_HIDDEN_CNT]);

            always_comb begin
                count = '0;
                for (int h = 0; h < `BNN_HIDDEN_CNT; h++) begin
                    count = count + score_t'(agree[h]); // popcount.
                end
            end

            assign scores[c] = count;
        end
    endgenerate

endmodule

//--- bnn_argmax.sv
`timescale 1ns/1ps

`include "bnn_settings.svh"

module bnn_argmax
    import bnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       hidden_valid,
    input  score_vec_t scores,
    output logic       out_valid,
    output class_t     prediction
);

    class_t best_idx;
    score_t best_score;
    score_t win_score;

    // ==================================================
    // scan for the largest score
    // ==================================================

    always_comb begin
        best_idx   = '0;
        best_score = scores[0];
        for (int c = 1; c < `BNN_CLASS_CNT; c++) begin
            if (scores[c] > best_score) begin // strict, so ties keep the lower index.
                best_idx   = class_t'(c);
                best_score = scores[c];
            end
        end
    end

    // ==================================================
    // stage 2 register
    // ==================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= hidden_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hidden_valid) begin
            prediction <= best_idx;
            win_score  <= best_score;
        end
    end

    a_prediction_range : assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> (prediction < `BNN_CLASS_CNT)
    );

    // winner checked against every score of the cycle it was taken from.
    genvar k;
    generate
        for (k = 0; k < `BNN_CLASS_CNT; k++) begin : g_win_check
            a_winner_max : assert property (
                @(posedge clk) disable iff (reset)
                out_valid |-> (win_score >= $past(scores[k]))
            );
        end
    endgenerate

endmodule

//--- bnn_classifier.sv
`timescale 1ns/1ps

module bnn_classifier
    import bnn_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  feature_vec_t features,
    output logic         out_valid,
    output class_t       prediction
);

    logic       hidden_valid;
    hidden_t    hidden;
    score_vec_t scores;

    // ==================================================
    // stage 1
    // ==================================================

    bnn_hidden_layer i_bnn_hidden_layer (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .features     (features),
        .hidden_valid (hidden_valid),
        .hidden       (hidden)
    );

    // ==================================================
    // stage 2
    // ==================================================

    // scores are combinational from the stage 1 register.
    bnn_output_layer i_bnn_output_layer (
        .hidden (hidden),
        .scores (scores)
    );

    bnn_argmax i_bnn_argmax (
        .clk          (clk),
        .reset        (reset),
        .hidden_valid (hidden_valid),
        .scores       (scores),
        .out_valid    (out_valid),
        .prediction   (prediction)
    );

endmodule

//--- tb_bnn_classifier.sv
`timescale 1ns/1ps

`include "bnn_settings.svh"
`include "bnn_weights.svh"

module tb_bnn_classifier
    import bnn_pkg::*;
;

    localparam logic [`BNN_HIDDEN_CNT*`BNN_FEAT_CNT-1:0] hidden_weights = `BNN_HIDDEN_WEIGHTS;
    localparam logic [`BNN_CLASS_CNT*`BNN_HIDDEN_CNT-1:0] output_weights = `BNN_OUTPUT_WEIGHTS;

    logic         clk;
    logic         reset;
    logic         in_valid;
    feature_vec_t features;
    logic         out_valid;
    class_t       prediction;

    class_t expected_q[$];
    logic   valid_d1 = 1'b0;
    logic   valid_d2 = 1'b0; // in_valid seen two edges back.
    logic   reset_seen = 1'b0;
    int     out_count = 0;

    bnn_classifier i_bnn_classifier (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .features   (features),
        .out_valid  (out_valid),
        .prediction (prediction)
    );

    always #5 clk = ~clk;

    // ==================================================
    // reference model and error handling
    // ==================================================

    function automatic class_t model_predict(feature_vec_t f);
        int      sum;
        int      score;
        int      best_score;
        class_t  best;
        hidden_t hid;
        hid        = '0;
        best       = '0;
        best_score = -1;
        for (int n = 0; n < `BNN_HIDDEN_CNT; n++) begin
            sum = 0;
            for (int i = 0; i < `BNN_FEAT_CNT; i++) begin
                if (hidden_weights[n*`BNN_FEAT_CNT + i]) begin
                    sum = sum + int'(f[i]);
                end else begin
                    sum = sum - int'(f[i]);
                end
            end
            hid[n] = (sum > 0); // strictly positive only.
        end
        for (int c = 0; c < `BNN_CLASS_CNT; c++) begin
            score = 0;
            for (int h = 0; h < `BNN_HIDDEN_CNT; h++) begin
                if (hid[h] == output_weights[c*`BNN_HIDDEN_CNT + h]) begin
                    score++;
                end
            end
            if (score > best_score) begin // first class keeps a tie.
                best_score = score;
                best       = class_t'(c);
            end
        end
        return best;
    endfunction

    function automatic feature_vec_t random_features();
        feature_vec_t v;
        for (int i = 0; i < `BNN_FEAT_CNT; i++) begin
            v[i] = feature_t'($urandom_range(15, 0));
        end
        return v;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_class(string name, class_t got, class_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            stop_on_error("wrong class index");
        end
    endtask

    task automatic check_valid(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            stop_on_error("wrong strobe value");
        end
    endtask

    // ==================================================
    // expected stream and output monitor
    // ==================================================

    always @(posedge clk) begin
        if (reset) begin
            reset_seen <= 1'b1;
            valid_d1   <= 1'b0;
            valid_d2   <= 1'b0;
            expected_q.delete(); // items in flight are flushed.
        end else begin
            valid_d1 <= in_valid;
            valid_d2 <= valid_d1;
            if (in_valid) begin
                expected_q.push_back(model_predict(features));
            end
        end
    end

    always @(negedge clk) begin
        if (reset_seen) begin
            check_valid("out_valid", out_valid, valid_d2);
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    stop_on_error("output strobe seen with no prediction expected");
                end else begin
                    check_class("prediction", prediction, expected_q.pop_front());
                    out_count++;
                end
            end
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            check_valid("out_valid", out_valid, 1'b0);
        end
        reset = 1'b0;
    endtask

    task automatic send_one(feature_vec_t f);
        features = f;
        in_valid = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(int limit);
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            if (cycles == limit) begin
                stop_on_error("timed out waiting for queued predictions");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================

    task automatic test_reset_state();
        int cycles;
        check_valid("out_valid", out_valid, 1'b0);
        features = '0;
        in_valid = 1'b1;
        cycles   = 0;
        do begin
            if (cycles == 10) begin
                stop_on_error("timed out waiting for out_valid after the zero vector");
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            cycles++;
        end while (!out_valid);
        if (cycles != 2) begin
            $display("MISMATCH latency: got 0x%h expected 0x%h", cycles, 2);
            stop_on_error("zero vector latency is wrong");
        end
        wait_drain(10);
    endtask

    task automatic test_corner_vectors();
        feature_vec_t v;
        for (int i = 0; i < `BNN_FEAT_CNT; i++) begin
            v[i] = 4'hf;
        end
        send_one(v);
        wait_drain(10);
        for (int i = 0; i < `BNN_FEAT_CNT; i++) begin
            v    = '0;
            v[i] = 4'hf; // one-hot feature.
            send_one(v);
            wait_drain(10);
        end
    endtask

    task automatic test_streaming();
        for (int i = 0; i < 300; i++) begin
            features = random_features();
            in_valid = 1'b1;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        wait_drain(10);
    endtask

    task automatic test_input_gaps();
        int sent;
        int start_count;
        sent        = 0;
        start_count = out_count;
        for (int i = 0; i < 200; i++) begin
            features = random_features();
            in_valid = ($urandom_range(2, 0) != 0);
            if (in_valid) begin
                sent++;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        wait_drain(10);
        if (out_count - start_count != sent) begin
            $display("MISMATCH output count: got 0x%h expected 0x%h",
                     out_count - start_count, sent);
            stop_on_error("outputs do not match the accepted inputs");
        end
    endtask

    task automatic test_reset_midstream();
        for (int i = 0; i < 6; i++) begin
            features = random_features();
            in_valid = 1'b1;
            @(posedge clk);
            #1;
        end
        features = random_features(); // still strobed on the first reset edge.
        apply_reset();
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        send_one(random_features());
        send_one(random_features());
        wait_drain(10);
    endtask

    initial begin
        void'($urandom(39));
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        features = '0;
        apply_reset();
        test_reset_state();
        test_corner_vectors();
        test_streaming();
        test_input_gaps();
        test_reset_midstream();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
bnn_pkg.sv
bnn_hidden_layer.sv
bnn_output_layer.sv
bnn_argmax.sv
bnn_classifier.sv
tb_bnn_classifier.sv

//--- Makefile
TOP = tb_bnn_classifier

.PHONY: sim clean

# the log decides pass or fail, since the tee hides the exit status
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f flist.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
